// ==== src/sysctrl_cmd_pkg.sv ====
// command codes, payload index width, signature bytes and core id
package sysctrl_cmd_pkg;

  // command codes, sent as the first byte of a frame
  // reply with signature and core id
  localparam logic [7:0] cmd_status  = 8'd0;
  // two MCU controlled leds
  localparam logic [7:0] cmd_leds    = 8'd1;
  // 24 bit rgb color, bytes arrive bit reversed
  localparam logic [7:0] cmd_color   = 8'd2;
  // button readback
  localparam logic [7:0] cmd_buttons = 8'd3;
  // OSD config value, id byte then value byte
  localparam logic [7:0] cmd_config  = 8'd4;
  // interrupt acknowledge and status readback
  localparam logic [7:0] cmd_irq     = 8'd5;

  // payload byte index, 1 is the first byte after the command
  localparam int idx_w = 4;

  // the index saturates here, long frames keep the last index
  localparam logic [idx_w-1:0] idx_max = idx_w'(15);

  // status reply pattern, unlikely on an unprogrammed device
  localparam logic [7:0] sig_byte0 = 8'h5c;
  localparam logic [7:0] sig_byte1 = 8'h42;

  // third status byte identifies the core
  localparam logic [7:0] core_id = 8'h02;

endpackage

// ==== src/sysctrl_cfg_pkg.sv ====
// OSD value ids, setting field widths and setting reset defaults
package sysctrl_cfg_pkg;

  // ascii ids sent as byte 1 of a config command
  // coldboot(3), reset(1) or run(0)
  localparam logic [7:0] id_reset     = "R";
  // scanlines none, 25%, 50%, 75%
  localparam logic [7:0] id_scanlines = "S";
  // volume mute, 33%, 66%, 100%
  localparam logic [7:0] id_volume    = "A";
  // 4:3 or 16:9 output
  localparam logic [7:0] id_wide      = "W";
  // floppy write protect none, A, B, both
  localparam logic [7:0] id_wprot     = "P";
  // joystick port input device selection
  localparam logic [7:0] id_port1     = "Q";
  localparam logic [7:0] id_port2     = "J";
  localparam logic [7:0] id_turbo     = "X";
  // PAL / NTSC
  localparam logic [7:0] id_video_std = "E";
  // pause while the OSD is open
  localparam logic [7:0] id_pause     = "G";
  localparam logic [7:0] id_sid_mode  = "K";
  localparam logic [7:0] id_georam    = "#";

  // field widths of the multi bit settings
  // wide screen, video std, pause and georam are single bits
  localparam int w_reset     = 2;
  localparam int w_scanlines = 2;
  localparam int w_volume    = 2;
  localparam int w_wprot     = 2;
  localparam int w_port      = 3;
  localparam int w_turbo     = 2;
  localparam int w_sid_mode  = 3;

  // values after reset, the MCU usually overrides them early
  localparam logic [w_reset-1:0]     def_reset     = '0;
  localparam logic [w_scanlines-1:0] def_scanlines = '0;
  localparam logic [w_volume-1:0]    def_volume    = w_volume'(2);
  localparam logic                   def_wide      = 1'b0;
  localparam logic [w_wprot-1:0]     def_wprot     = '0;
  // port 1 off, port 2 db9 joystick
  localparam logic [w_port-1:0]      def_port1     = w_port'(7);
  localparam logic [w_port-1:0]      def_port2     = '0;
  localparam logic [w_turbo-1:0]     def_turbo     = '0;
  localparam logic                   def_video_std = 1'b0;
  localparam logic                   def_pause     = 1'b0;
  localparam logic [w_sid_mode-1:0]  def_sid_mode  = '0;
  localparam logic                   def_georam    = 1'b0;

endpackage

// ==== src/cmd_framer.sv ====
// frame start detection, command register and payload byte index
`timescale 1ns/1ps

module cmd_framer
  import sysctrl_cmd_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             data_in_strobe,
  input  logic             data_in_start,
  input  logic [7:0]       data_in,
  output logic             payload_valid,
  output logic [7:0]       command,
  output logic [idx_w-1:0] byte_idx
);

  // set by the first start byte and held until reset
  logic frame_open;

  // payload bytes only count inside a frame
  // a start byte is never payload because it opens the next frame
  assign payload_valid = data_in_strobe && !data_in_start && frame_open;

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_open <= 1'b0;
      command    <= '0;
      byte_idx   <= '0;
    end else if (data_in_strobe) begin
      if (data_in_start) begin
        // start byte is the command code itself
        frame_open <= 1'b1;
        command    <= data_in;
        byte_idx   <= idx_w'(1);
      end else if (frame_open) begin
        // advance after each payload byte and hold at the top
        if (byte_idx != idx_max) begin
          byte_idx <= byte_idx + idx_w'(1);
        end
      end
      // strobes before any start byte fall through here untouched
    end
  end

  // index 0 only exists before the first frame, so payload never sees it
  a_idx_nonzero: assert property (
    @(posedge clk) disable iff (reset)
    payload_valid |-> byte_idx != '0
  ) else $error("payload byte presented with index 0");

endmodule

// ==== src/osd_config_store.sv ====
// osd_config_store: led, rgb color and OSD setting registers for commands 1, 2 and 4
`timescale 1ns/1ps

module osd_config_store
  import sysctrl_cmd_pkg::*;
  import sysctrl_cfg_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  payload_valid,
  input  logic [7:0]            command,
  input  logic [idx_w-1:0]      byte_idx,
  input  logic [7:0]            data_in,
  output logic [1:0]            leds,
  output logic [23:0]           color,
  output logic [w_reset-1:0]    system_reset,
  output logic [w_scanlines-1:0] system_scanlines,
  output logic [w_volume-1:0]   system_volume,
  output logic                  system_wide_screen,
  output logic [w_wprot-1:0]    system_floppy_wprot,
  output logic [w_port-1:0]     system_port_1,
  output logic [w_port-1:0]     system_port_2,
  output logic [w_turbo-1:0]    system_turbo_mode,
  output logic                  system_video_std,
  output logic                  system_pause,
  output logic [w_sid_mode-1:0] system_sid_mode,
  output logic                  system_georam
);

  // id byte of the current config command
  logic [7:0] cfg_id;
  // color bytes arrive msb last, flip them before storing
  logic [7:0] data_in_rev;

  assign data_in_rev = {<<{data_in}};

  always_ff @(posedge clk) begin
    if (reset) begin
      // leds off, color black so the rgb led is dark
      leds                <= 2'b00;
      color               <= 24'h000000;
      cfg_id              <= 8'h00;
      system_reset        <= def_reset;
      system_scanlines    <= def_scanlines;
      system_volume       <= def_volume;
      system_wide_screen  <= def_wide;
      system_floppy_wprot <= def_wprot;
      system_port_1       <= def_port1;
      system_port_2       <= def_port2;
      system_turbo_mode   <= def_turbo;
      system_video_std    <= def_video_std;
      system_pause        <= def_pause;
      system_sid_mode     <= def_sid_mode;
      system_georam       <= def_georam;
    end else if (payload_valid) begin
      if (command == cmd_leds && byte_idx == idx_w'(1)) begin
        leds <= data_in[1:0];
      end
      // byte order on the wire is green, blue, red
      if (command == cmd_color) begin
        if (byte_idx == idx_w'(1)) color[15:8]  <= data_in_rev;
        if (byte_idx == idx_w'(2)) color[7:0]   <= data_in_rev;
        if (byte_idx == idx_w'(3)) color[23:16] <= data_in_rev;
      end
      if (command == cmd_config) begin
        // first byte picks the setting, second byte carries its value
        if (byte_idx == idx_w'(1)) cfg_id <= data_in;
        if (byte_idx == idx_w'(2)) begin
          case (cfg_id)
            id_reset:     system_reset        <= data_in[w_reset-1:0];
            id_scanlines: system_scanlines    <= data_in[w_scanlines-1:0];
            id_volume:    system_volume       <= data_in[w_volume-1:0];
            id_wide:      system_wide_screen  <= data_in[0];
            id_wprot:     system_floppy_wprot <= data_in[w_wprot-1:0];
            id_port1:     system_port_1       <= data_in[w_port-1:0];
            id_port2:     system_port_2       <= data_in[w_port-1:0];
            id_turbo:     system_turbo_mode   <= data_in[w_turbo-1:0];
            id_video_std: system_video_std    <= data_in[0];
            id_pause:     system_pause        <= data_in[0];
            id_sid_mode:  system_sid_mode     <= data_in[w_sid_mode-1:0];
            id_georam:    system_georam       <= data_in[0];
            // unknown ids are silently dropped
            default: ;
          endcase
        end
      end
    end
  end

  // every register here moves only on the edge right after a payload byte
  a_write_needs_payload: assert property (
    @(posedge clk) disable iff (reset)
    !$past(reset) && !$past(payload_valid) |->
      $stable({leds, color, system_reset, system_scanlines, system_volume,
               system_wide_screen, system_floppy_wprot, system_port_1,
               system_port_2, system_turbo_mode, system_video_std,
               system_pause, system_sid_mode, system_georam})
  ) else $error("config output changed without a payload byte");

endmodule

// ==== src/irq_status_unit.sv ====
// coldboot flag, interrupt line, acknowledge pulse and status byte
`timescale 1ns/1ps

module irq_status_unit
  import sysctrl_cmd_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             payload_valid,
  input  logic [7:0]       command,
  input  logic [idx_w-1:0] byte_idx,
  input  logic [7:0]       data_in,
  input  logic [7:0]       int_in,
  output logic             int_out_n,
  output logic [7:0]       int_ack,
  output logic [7:0]       irq_status
);

  // reset here is the power-on reset, so the MCU sees a cold boot
  logic coldboot;

  // active low request to the MCU for any pending source or the cold boot
  assign int_out_n = !((int_in != 8'h00) || coldboot);

  // bit 0 reports the cold boot in place of int_in[0]
  assign irq_status = {int_in[7:1], coldboot};

  always_ff @(posedge clk) begin
    if (reset) begin
      int_ack  <= 8'h00;
      coldboot <= 1'b1;
    end else begin
      // ack is a single cycle pulse by default
      int_ack <= 8'h00;
      // ack bit 0 clears the cold boot notice one edge later
      if (int_ack[0]) begin
        coldboot <= 1'b0;
      end
      if (payload_valid && command == cmd_irq && byte_idx == idx_w'(1)) begin
        int_ack <= data_in;
      end
    end
  end

  // ack comes from byte 1 only, so a pulse never stretches
  a_ack_single_cycle: assert property (
    @(posedge clk) disable iff (reset)
    int_ack != 8'h00 |=> int_ack == 8'h00
  ) else $error("int_ack held for more than one cycle");

endmodule

// ==== src/reply_mux.sv ====
// registered reply byte for status, button and interrupt commands
`timescale 1ns/1ps

module reply_mux
  import sysctrl_cmd_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             payload_valid,
  input  logic [7:0]       command,
  input  logic [idx_w-1:0] byte_idx,
  input  logic [1:0]       buttons,
  input  logic [7:0]       irq_status,
  output logic [7:0]       data_out
);

  // the MCU clocks out the reply while it sends payload bytes,
  // so each reply byte is ready one cycle after its strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= 8'h00;
    end else if (payload_valid) begin
      case (command)
        cmd_status: begin
          // signature then core id while later indices keep the last byte
          case (byte_idx)
            idx_w'(1): data_out <= sig_byte0;
            idx_w'(2): data_out <= sig_byte1;
            idx_w'(3): data_out <= core_id;
            default: ;
          endcase
        end
        // buttons and irq status are sampled on every payload byte
        cmd_buttons: data_out <= {6'b000000, buttons};
        cmd_irq:     data_out <= irq_status;
        // commands without a reply leave data_out alone
        default: ;
      endcase
    end
  end

endmodule

// ==== src/sysctrl_top.sv ====
// sysctrl_top: system control block built from framer, config store, irq unit and reply mux
`timescale 1ns/1ps

module sysctrl_top
  import sysctrl_cmd_pkg::*;
  import sysctrl_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  // byte stream from the MCU
  input  logic                   data_in_strobe,
  input  logic                   data_in_start,
  input  logic [7:0]             data_in,
  output logic [7:0]             data_out,
  // interrupt interface
  output logic                   int_out_n,
  input  logic [7:0]             int_in,
  output logic [7:0]             int_ack,
  // board io
  input  logic [1:0]             buttons,
  output logic [1:0]             leds,
  output logic [23:0]            color,
  // OSD settings
  output logic [w_reset-1:0]     system_reset,
  output logic [w_scanlines-1:0] system_scanlines,
  output logic [w_volume-1:0]    system_volume,
  output logic                   system_wide_screen,
  output logic [w_wprot-1:0]     system_floppy_wprot,
  output logic [w_port-1:0]      system_port_1,
  output logic [w_port-1:0]      system_port_2,
  output logic [w_turbo-1:0]     system_turbo_mode,
  output logic                   system_video_std,
  output logic                   system_pause,
  output logic [w_sid_mode-1:0]  system_sid_mode,
  output logic                   system_georam
);

  // payload bus shared by the three consumers
  logic             payload_valid;
  logic [7:0]       command;
  logic [idx_w-1:0] byte_idx;
  // status byte from the irq unit into the reply
  logic [7:0]       irq_status;

  cmd_framer i_framer (
    .clk            (clk),
    .reset          (reset),
    .data_in_strobe (data_in_strobe),
    .data_in_start  (data_in_start),
    .data_in        (data_in),
    .payload_valid  (payload_valid),
    .command        (command),
    .byte_idx       (byte_idx)
  );

  osd_config_store i_store (
    .clk                 (clk),
    .reset               (reset),
    .payload_valid       (payload_valid),
    .command             (command),
    .byte_idx            (byte_idx),
    .data_in             (data_in),
    .leds                (leds),
    .color               (color),
    .system_reset        (system_reset),
    .system_scanlines    (system_scanlines),
    .system_volume       (system_volume),
    .system_wide_screen  (system_wide_screen),
    .system_floppy_wprot (system_floppy_wprot),
    .system_port_1       (system_port_1),
    .system_port_2       (system_port_2),
    .system_turbo_mode   (system_turbo_mode),
    .system_video_std    (system_video_std),
    .system_pause        (system_pause),
    .system_sid_mode     (system_sid_mode),
    .system_georam       (system_georam)
  );

  irq_status_unit i_irq (
    .clk           (clk),
    .reset         (reset),
    .payload_valid (payload_valid),
    .command       (command),
    .byte_idx      (byte_idx),
    .data_in       (data_in),
    .int_in        (int_in),
    .int_out_n     (int_out_n),
    .int_ack       (int_ack),
    .irq_status    (irq_status)
  );

  reply_mux i_reply (
    .clk           (clk),
    .reset         (reset),
    .payload_valid (payload_valid),
    .command       (command),
    .byte_idx      (byte_idx),
    .buttons       (buttons),
    .irq_status    (irq_status),
    .data_out      (data_out)
  );

endmodule

// ==== dv/sysctrl_tb.sv ====
// clock, reset, random command frames, reference model, compare task and timeout
`timescale 1ns/1ps

module sysctrl_tb
  import sysctrl_cmd_pkg::*;
  import sysctrl_cfg_pkg::*;
();

  localparam int n_frames = 300;
  // at most 18 bytes per frame and up to 4 cycles per byte with its gap
  localparam int timeout_cycles = n_frames * 18 * 4 + 3400;

  logic clk = 1'b0;
  logic reset;
  logic data_in_strobe, data_in_start;
  logic [7:0] data_in, data_out, int_in, int_ack;
  logic int_out_n;
  logic [1:0] buttons, leds;
  logic [23:0] color;
  logic [w_reset-1:0] system_reset;
  logic [w_scanlines-1:0] system_scanlines;
  logic [w_volume-1:0] system_volume;
  logic system_wide_screen, system_video_std, system_pause, system_georam;
  logic [w_wprot-1:0] system_floppy_wprot;
  logic [w_port-1:0] system_port_1, system_port_2;
  logic [w_turbo-1:0] system_turbo_mode;
  logic [w_sid_mode-1:0] system_sid_mode;

  integer seed;
  int cycles = 0;

  // model state with the settings in the order of the id table
  logic m_open, m_coldboot;
  logic [7:0] m_cmd, m_cfg_id, m_ack, m_dout;
  logic [3:0] m_idx;
  logic [1:0] m_leds;
  logic [23:0] m_color;
  logic [2:0] m_cfg [12];
  logic [7:0] cfg_ids [12];
  int cfg_w [12];
  logic [2:0] cfg_def [12];

  sysctrl_top i_dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("CHECKS FAILED");
      $fatal(1, "timeout, the frames did not finish within %0d cycles", timeout_cycles);
    end
  end

  function automatic int rand_range(input int n);
    int v;
    v = $random(seed);
    return (v & 32'h7fffffff) % n;
  endfunction

  // color bytes come msb last on the wire
  function automatic logic [7:0] bit_reverse(input logic [7:0] b);
    logic [7:0] r;
    int i;
    for (i = 0; i < 8; i++)
      r[i] = b[7-i];
    return r;
  endfunction

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s is %0h, model expects %0h", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "DUT output differs from the reference model");
    end
  endtask

  task automatic model_reset();
    m_open = 1'b0;
    m_cmd = 8'h00;
    m_idx = 4'd0;
    m_leds = 2'b00;
    m_color = 24'h000000;
    m_cfg_id = 8'h00;
    m_cfg = cfg_def;
    m_coldboot = 1'b1;
    m_ack = 8'h00;
    m_dout = 8'h00;
  endtask

  // next state for the coming edge with old values read before overwrite
  task automatic model_update(input logic stb, input logic st, input logic [7:0] d);
    logic payload;
    int i;
    payload = stb && !st && m_open;
    if (payload) begin
      // reply uses coldboot as it is before this edge
      if (m_cmd == cmd_status && m_idx == 4'd1) m_dout = 8'h5c;
      if (m_cmd == cmd_status && m_idx == 4'd2) m_dout = 8'h42;
      if (m_cmd == cmd_status && m_idx == 4'd3) m_dout = 8'h02;
      if (m_cmd == cmd_buttons) m_dout = {6'b000000, buttons};
      if (m_cmd == cmd_irq) m_dout = {int_in[7:1], m_coldboot};
      if (m_cmd == cmd_leds && m_idx == 4'd1) m_leds = d[1:0];
      // green, blue, red order
      if (m_cmd == cmd_color && m_idx == 4'd1) m_color[15:8] = bit_reverse(d);
      if (m_cmd == cmd_color && m_idx == 4'd2) m_color[7:0] = bit_reverse(d);
      if (m_cmd == cmd_color && m_idx == 4'd3) m_color[23:16] = bit_reverse(d);
      if (m_cmd == cmd_config && m_idx == 4'd2) begin
        for (i = 0; i < 12; i++)
          if (cfg_ids[i] == m_cfg_id) m_cfg[i] = d[2:0] & 3'((1 << cfg_w[i]) - 1);
      end
      if (m_cmd == cmd_config && m_idx == 4'd1) m_cfg_id = d;
    end
    // ack bit 0 of the previous pulse clears coldboot
    if (m_ack[0]) m_coldboot = 1'b0;
    m_ack = (payload && m_cmd == cmd_irq && m_idx == 4'd1) ? d : 8'h00;
    if (stb && st) begin
      m_open = 1'b1;
      m_cmd = d;
      m_idx = 4'd1;
    end else if (payload && m_idx != 4'd15) begin
      m_idx = m_idx + 4'd1;
    end
  endtask

  task automatic check_outputs();
    compare(32'(leds), 32'(m_leds), "leds");
    compare(32'(color), 32'(m_color), "color");
    compare(32'(system_reset), 32'(m_cfg[0]), "system_reset");
    compare(32'(system_scanlines), 32'(m_cfg[1]), "system_scanlines");
    compare(32'(system_volume), 32'(m_cfg[2]), "system_volume");
    compare(32'(system_wide_screen), 32'(m_cfg[3]), "system_wide_screen");
    compare(32'(system_floppy_wprot), 32'(m_cfg[4]), "system_floppy_wprot");
    compare(32'(system_port_1), 32'(m_cfg[5]), "system_port_1");
    compare(32'(system_port_2), 32'(m_cfg[6]), "system_port_2");
    compare(32'(system_turbo_mode), 32'(m_cfg[7]), "system_turbo_mode");
    compare(32'(system_video_std), 32'(m_cfg[8]), "system_video_std");
    compare(32'(system_pause), 32'(m_cfg[9]), "system_pause");
    compare(32'(system_sid_mode), 32'(m_cfg[10]), "system_sid_mode");
    compare(32'(system_georam), 32'(m_cfg[11]), "system_georam");
    compare(32'(int_ack), 32'(m_ack), "int_ack");
    compare(32'(data_out), 32'(m_dout), "data_out");
    // line released only with no pending source and coldboot cleared
    compare(32'(int_out_n), 32'((int_in == 8'h00) && !m_coldboot), "int_out_n");
  endtask

  // check the last edge and then drive the next cycle on the falling edge
  task automatic drive_cycle(input logic stb, input logic st, input logic [7:0] d,
                             input logic env);
    @(negedge clk);
    check_outputs();
    data_in_strobe = stb;
    data_in_start = st;
    data_in = d;
    if (env) begin
      int_in = (rand_range(2) == 0) ? 8'h00 : 8'(rand_range(256));
      buttons = 2'(rand_range(4));
    end
    model_update(stb, st, d);
  endtask

  // command 6 stands for an unknown command with up to 17 payload bytes
  task automatic send_frame();
    int cmd;
    int len;
    int b;
    int sel;
    logic [7:0] d;
    cmd = rand_range(7);
    len = rand_range(18);
    repeat (rand_range(4)) drive_cycle(1'b0, 1'b0, 8'(rand_range(256)), 1'b0);
    drive_cycle(1'b1, 1'b1, 8'(cmd), 1'b1);
    for (b = 1; b <= len; b++) begin
      repeat (rand_range(4)) drive_cycle(1'b0, 1'b0, 8'(rand_range(256)), 1'b0);
      d = 8'(rand_range(256));
      // config id from the known set or a stray byte
      if (cmd == 4 && b == 1) begin
        sel = rand_range(13);
        if (sel < 12) d = cfg_ids[sel];
      end
      drive_cycle(1'b1, 1'b0, d, 1'b0);
    end
  endtask

  initial begin
    seed = 47;
    reset = 1'b1;
    data_in_strobe = 1'b0;
    data_in_start = 1'b0;
    data_in = 8'h00;
    int_in = 8'h00;
    buttons = 2'b00;
    cfg_ids = '{id_reset, id_scanlines, id_volume, id_wide, id_wprot, id_port1,
                id_port2, id_turbo, id_video_std, id_pause, id_sid_mode, id_georam};
    cfg_w = '{w_reset, w_scanlines, w_volume, 1, w_wprot, w_port,
              w_port, w_turbo, 1, 1, w_sid_mode, 1};
    // volume 2, port 1 off, all else zero
    cfg_def = '{3'd0, 3'd0, 3'd2, 3'd0, 3'd0, 3'd7, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0};
    model_reset();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    check_outputs();
    compare(32'(int_out_n), 32'd0, "int_out_n after reset");
    // payload strobes with no frame open must be ignored
    repeat (5) drive_cycle(1'b1, 1'b0, 8'(rand_range(256)), 1'b0);
    repeat (n_frames) send_frame();
    repeat (4) drive_cycle(1'b0, 1'b0, 8'h00, 1'b0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== sysctrl.f ====
src/sysctrl_cmd_pkg.sv
src/sysctrl_cfg_pkg.sv
src/cmd_framer.sv
src/osd_config_store.sv
src/irq_status_unit.sv
src/reply_mux.sv
src/sysctrl_top.sv
dv/sysctrl_tb.sv

// ==== Makefile ====
TOOL       := verilator
TOP        := sysctrl_tb
FLIST      := sysctrl.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)
